//--- files.f
+incdir+.
spi_ctrl_pkg.sv
credit_fifo.sv
msg_receiver.sv
msg_decoder.sv
cmd6_capture.sv
resp_serializer.sv
spi_ctrl_top.sv
tb_spi_ctrl.sv

//--- Makefile
TOP := tb_spi_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test completed successfully" sim.log || (echo "No pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- tb_spi_ctrl.sv
`include "spi_ctrl_defines.svh"

module tb_spi_ctrl;
    import spi_ctrl_pkg::*;

    // About 70 cycles per message and per response, 2 per data-in word
    localparam int N_MSGS      = 18;
    localparam int N_RESPS     = 11;
    localparam int N_WORDS     = 2 * `BLOCK_WORDS + 12;
    localparam int N_QUIET     = 2;
    localparam int CYCLE_LIMIT = N_MSGS * 70 + N_RESPS * 70 + N_WORDS * 2 +
                                 N_QUIET * (`RESP_LEN + 8) + 500;

    logic        sd_datInWrite_clk = 1'b0;
    logic        sd_datInWrite_rst_;
    logic        data_in;
    logic        datin_valid;
    datin_word_t datin_word;
    logic        data_out;
    logic        data_out_en;
    logic        datin_credit;
    logic [3:0]  led;

    // Model state
    logic [3:0]   led_model;
    cmd6_status_t status_model;
    int           word_idx_model;
    logic [7:0]   bad_model;
    logic [7:0]   drop_model;
    resp_t        exp_q[$];

    int          exp_count;
    int          rx_count;
    int          rx_bits;
    resp_t       rx_shift;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          sent_words;
    int          credit_pulses;
    int          cycle_cnt = 0;
    logic [31:0] lfsr_q;
    string       cur_test;

    spi_ctrl_top dut0 (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .data_in            (data_in),
        .datin_valid        (datin_valid),
        .datin_word         (datin_word),
        .data_out           (data_out),
        .data_out_en        (data_out_en),
        .datin_credit       (datin_credit),
        .led                (led)
    );

    always #10 sd_datInWrite_clk = ~sd_datInWrite_clk;

    // ==============================
    // Random source and reference
    // ==============================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic known_type(input logic [7:0] t);
        return (t == `TYPE_NOP) || (t == `TYPE_LED_SET) ||
               (t == `TYPE_ECHO) || (t == `TYPE_CMD6_STATUS);
    endfunction

    function automatic resp_t expect_resp(input msg_t m, input cmd6_status_t st,
                                          input logic [7:0] drops, input logic [7:0] bads);
        resp_t r;
        r = '0;
        r.resp_type = m.msg_type;
        if (m.msg_type == `TYPE_ECHO) begin
            r.payload = m.arg;
        end else if (m.msg_type == `TYPE_CMD6_STATUS) begin
            r.payload[55:43] = st;
            r.payload[42:35] = drops;
            r.payload[34:27] = bads;
        end
        return r;
    endfunction

    // Block word position decides what a word does to the status
    task automatic model_word(input datin_word_t w);
        if (word_idx_model == `ACCESS_WORD) begin
            status_model.access_mode = w[11:8];
        end
        if (word_idx_model == `BLOCK_WORDS - 1) begin
            status_model.block_done = 1'b1;
            status_model.block_count++;
            word_idx_model = 0;
        end else begin
            if (word_idx_model == 0) begin
                status_model.block_done = 1'b0;
            end
            word_idx_model++;
        end
    endtask

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: response expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_status(input string name, input cmd6_status_t exp,
                                input cmd6_status_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: cmd6 status expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_led(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: led expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    // Serial output must stay disabled for one response length
    task automatic check_no_response(input string name);
        int en_cycles;
        en_cycles = 0;
        repeat (`RESP_LEN + 8) begin
            @(negedge sd_datInWrite_clk);
            if (data_out_en) begin
                en_cycles++;
            end
        end
        check_count(name, 0, en_cycles);
    endtask

    // ==============================
    // Monitors
    // ==============================

    // Rebuild each response from the enabled cycles
    always @(negedge sd_datInWrite_clk) begin
        resp_t exp_r;
        if (data_out_en) begin
            rx_shift = {rx_shift[`RESP_LEN-2:0], data_out};
            rx_bits++;
            if (rx_bits == `RESP_LEN) begin
                rx_bits = 0;
                if (exp_q.size() == 0) begin
                    $display("ERROR %s: response %h sent with none expected", cur_test, rx_shift);
                    err_cnt++;
                end else begin
                    exp_r = exp_q.pop_front();
                    check_resp(cur_test, exp_r, rx_shift);
                    if (exp_r.resp_type == `TYPE_CMD6_STATUS) begin
                        check_status(cur_test, exp_r.payload[55:43], rx_shift.payload[55:43]);
                    end
                    rx_count++;
                end
            end
        end else if (rx_bits != 0) begin
            $display("ERROR %s: data_out_en fell after %0d response bits", cur_test, rx_bits);
            err_cnt++;
            rx_bits = 0;
        end
    end

    always @(negedge sd_datInWrite_clk) begin
        if (datin_credit) begin
            credit_pulses++;
        end
        if (credit_pulses > sent_words) begin
            $display("ERROR %s: credit returned with no word outstanding", cur_test);
            err_cnt++;
        end
    end

    always @(posedge sd_datInWrite_clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    // Start bit, then the message MSB first
    task automatic send_msg(input msg_t m);
        logic [`MSG_LEN:0] frame;
        int                i;
        frame = {1'b1, m};
        for (i = `MSG_LEN; i >= 0; i--) begin
            @(posedge sd_datInWrite_clk);
            #2 data_in = frame[i];
        end
        @(posedge sd_datInWrite_clk);
        #2 data_in = 1'b0;
    endtask

    task automatic run_msg(input msg_t m);
        if (known_type(m.msg_type) && m.msg_type[`TYPE_RESP_BIT]) begin
            exp_q.push_back(expect_resp(m, status_model, drop_model, bad_model));
            exp_count++;
        end
        if (!known_type(m.msg_type)) begin
            bad_model++;
        end
        if (m.msg_type == `TYPE_LED_SET) begin
            led_model = m.arg[3:0];
        end
        send_msg(m);
        // led settles on the edge after msg_valid
        repeat (2) @(negedge sd_datInWrite_clk);
        wait (rx_count == exp_count);
    endtask

    task automatic write_words(input int n);
        int          left;
        int          wait_cycles;
        datin_word_t w;
        left = n;
        while (left > 0) begin
            @(posedge sd_datInWrite_clk);
            #2;
            if (sent_words - credit_pulses < `DATIN_DEPTH) begin
                w           = datin_word_t'(rand_bits(16));
                datin_valid = 1'b1;
                datin_word  = w;
                sent_words++;
                left--;
                model_word(w);
            end else begin
                datin_valid = 1'b0;
            end
        end
        @(posedge sd_datInWrite_clk);
        #2 datin_valid = 1'b0;
        // Last credit follows its pop within a few cycles
        wait_cycles = 0;
        while (credit_pulses != sent_words && wait_cycles < `DATIN_DEPTH + 4) begin
            @(posedge sd_datInWrite_clk);
            wait_cycles++;
        end
        check_count({cur_test, " credit pulses"}, sent_words, credit_pulses);
        @(negedge sd_datInWrite_clk);
    endtask

    task automatic finish_test(input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("PASS %s", cur_test);
        end else begin
            fail_cnt++;
            $display("FAIL %s with %0d errors", cur_test, err_cnt - errs_before);
        end
    endtask

    initial begin
        msg_t m;
        int   errs;
        int   i;
        sd_datInWrite_rst_ = 1'b0;
        data_in            = 1'b0;
        datin_valid        = 1'b0;
        datin_word         = '0;
        lfsr_q             = 32'd66;
        led_model          = '0;
        status_model       = '0;
        word_idx_model     = 0;
        bad_model          = '0;
        drop_model         = '0;
        exp_count          = 0;
        rx_count           = 0;
        rx_bits            = 0;
        err_cnt            = 0;
        pass_cnt           = 0;
        fail_cnt           = 0;
        sent_words         = 0;
        credit_pulses      = 0;

        cur_test = "reset";
        errs     = err_cnt;
        repeat (3) @(posedge sd_datInWrite_clk);
        @(negedge sd_datInWrite_clk);
        check_led(cur_test, 4'h0, led);
        check_bit("reset data_out_en", 1'b0, data_out_en);
        check_bit("reset datin_credit", 1'b0, datin_credit);
        @(posedge sd_datInWrite_clk);
        #2 sd_datInWrite_rst_ = 1'b1;
        m.msg_type = `TYPE_CMD6_STATUS;
        m.arg      = '0;
        run_msg(m);
        finish_test(errs);

        cur_test = "echo";
        errs     = err_cnt;
        for (i = 0; i < 8; i++) begin
            m.msg_type = `TYPE_ECHO;
            m.arg      = `ARG_LEN'(rand_bits(`ARG_LEN));
            run_msg(m);
        end
        finish_test(errs);

        cur_test = "led_set";
        errs     = err_cnt;
        for (i = 0; i < 4; i++) begin
            m.msg_type = `TYPE_LED_SET;
            m.arg      = `ARG_LEN'(rand_bits(`ARG_LEN));
            run_msg(m);
            check_led(cur_test, led_model, led);
        end
        // Nop must leave led alone
        m.msg_type = `TYPE_NOP;
        m.arg      = `ARG_LEN'(rand_bits(`ARG_LEN));
        run_msg(m);
        check_led(cur_test, led_model, led);
        finish_test(errs);

        cur_test = "cmd6_capture";
        errs     = err_cnt;
        write_words(2 * `BLOCK_WORDS);
        m.msg_type = `TYPE_CMD6_STATUS;
        m.arg      = '0;
        run_msg(m);
        finish_test(errs);

        cur_test = "credits";
        errs     = err_cnt;
        write_words(12);
        finish_test(errs);

        cur_test = "bad_type";
        errs     = err_cnt;
        m.msg_type = 8'h42;
        m.arg      = `ARG_LEN'(rand_bits(`ARG_LEN));
        run_msg(m);
        check_no_response("bad_type 42 enabled cycles");
        m.msg_type = 8'hC3;
        m.arg      = `ARG_LEN'(rand_bits(`ARG_LEN));
        run_msg(m);
        check_no_response("bad_type C3 enabled cycles");
        m.msg_type = `TYPE_CMD6_STATUS;
        m.arg      = '0;
        run_msg(m);
        finish_test(errs);

        $display("Summary: %0d passed, %0d with errors, %0d errors in all",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- spi_ctrl_top.sv
`include "spi_ctrl_defines.svh"

module spi_ctrl_top (
    input  logic                      sd_datInWrite_clk,
    input  logic                      sd_datInWrite_rst_,
    input  logic                      data_in,
    input  logic                      datin_valid,
    input  spi_ctrl_pkg::datin_word_t datin_word,
    output logic                      data_out,
    output logic                      data_out_en,
    output logic                      datin_credit,
    output logic [3:0]                led
);
    import spi_ctrl_pkg::*;

    msg_t         msg;
    logic         msg_valid;
    datin_word_t  datin_head;
    logic         datin_not_empty;
    cmd6_status_t cmd6_status;
    resp_t        resp_in;
    logic         resp_push;
    resp_t        resp_head;
    logic         resp_not_empty;
    logic         resp_pop;
    logic         resp_credit;

    // ==============================
    // Input side
    // ==============================
    msg_receiver u_msg_receiver (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .data_in            (data_in),
        .msg                (msg),
        .msg_valid          (msg_valid)
    );

    // Drained every cycle it holds a word
    credit_fifo #(
        .payload_t (datin_word_t),
        .DEPTH     (`DATIN_DEPTH)
    ) u_datin_fifo (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .push               (datin_valid),
        .push_data          (datin_word),
        .pop                (datin_not_empty),
        .pop_data           (datin_head),
        .not_empty          (datin_not_empty),
        .credit             (datin_credit)
    );

    // ==============================
    // Processing
    // ==============================
    cmd6_capture u_cmd6_capture (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .word               (datin_head),
        .word_valid         (datin_not_empty),
        .status             (cmd6_status)
    );

    msg_decoder u_msg_decoder (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .msg                (msg),
        .msg_valid          (msg_valid),
        .cmd6_status        (cmd6_status),
        .resp_credit        (resp_credit),
        .resp               (resp_in),
        .resp_push          (resp_push),
        .led                (led)
    );

    // ==============================
    // Output side
    // ==============================
    credit_fifo #(
        .payload_t (resp_t),
        .DEPTH     (`RESP_DEPTH)
    ) u_resp_fifo (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .push               (resp_push),
        .push_data          (resp_in),
        .pop                (resp_pop),
        .pop_data           (resp_head),
        .not_empty          (resp_not_empty),
        .credit             (resp_credit)
    );

    resp_serializer u_resp_serializer (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .resp               (resp_head),
        .resp_avail         (resp_not_empty),
        .resp_pop           (resp_pop),
        .data_out           (data_out),
        .data_out_en        (data_out_en)
    );

endmodule

//--- resp_serializer.sv
`include "spi_ctrl_defines.svh"

module resp_serializer (
    input  logic                sd_datInWrite_clk,
    input  logic                sd_datInWrite_rst_,
    input  spi_ctrl_pkg::resp_t resp,
    input  logic                resp_avail,
    output logic                resp_pop,
    output logic                data_out,
    output logic                data_out_en
);
    localparam int CNT_W = $clog2(`RESP_LEN);

    logic                 busy;
    logic [CNT_W-1:0]     bit_cnt;
    logic [`RESP_LEN-1:0] shift_q;

    // Take the next response only between transfers
    assign resp_pop = !busy && resp_avail;

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (resp_pop) begin
            busy    <= 1'b1;
            bit_cnt <= CNT_W'(`RESP_LEN - 1);
        end else if (busy) begin
            bit_cnt <= bit_cnt - 1'b1;
            if (bit_cnt == '0) begin
                busy <= 1'b0;
            end
        end
    end

    // MSB first
    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp_pop) begin
            shift_q <= resp;
        end else if (busy) begin
            shift_q <= {shift_q[`RESP_LEN-2:0], 1'b0};
        end
    end

    assign data_out    = shift_q[`RESP_LEN-1];
    assign data_out_en = busy;

endmodule

//--- cmd6_capture.sv
`include "spi_ctrl_defines.svh"

module cmd6_capture (
    input  logic                       sd_datInWrite_clk,
    input  logic                       sd_datInWrite_rst_,
    input  spi_ctrl_pkg::datin_word_t  word,
    input  logic                       word_valid,
    output spi_ctrl_pkg::cmd6_status_t status
);
    import spi_ctrl_pkg::*;

    localparam int IDX_W = $clog2(`BLOCK_WORDS);

    logic [IDX_W-1:0] word_idx;
    logic             last_word;
    cmd6_status_t     status_q;

    assign last_word = (word_idx == IDX_W'(`BLOCK_WORDS - 1));

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_idx <= '0;
            status_q <= '0;
        end else if (word_valid) begin
            word_idx <= last_word ? '0 : word_idx + 1'b1;

            // Access mode sits in bits 11:8 of this word
            if (word_idx == IDX_W'(`ACCESS_WORD)) begin
                status_q.access_mode <= word[11:8];
            end

            if (last_word) begin
                status_q.block_done  <= 1'b1;
                status_q.block_count <= status_q.block_count + 1'b1;
            end else if (word_idx == '0) begin
                // New block started
                status_q.block_done <= 1'b0;
            end
        end
    end

    assign status = status_q;

endmodule

//--- msg_decoder.sv
`include "spi_ctrl_defines.svh"

module msg_decoder (
    input  logic                       sd_datInWrite_clk,
    input  logic                       sd_datInWrite_rst_,
    input  spi_ctrl_pkg::msg_t         msg,
    input  logic                       msg_valid,
    input  spi_ctrl_pkg::cmd6_status_t cmd6_status,
    input  logic                       resp_credit,
    output spi_ctrl_pkg::resp_t        resp,
    output logic                       resp_push,
    output logic [3:0]                 led
);
    import spi_ctrl_pkg::*;

    localparam int CRED_W = $clog2(`RESP_DEPTH + 1);

    logic [CRED_W-1:0] credit_cnt;
    logic [7:0]        drop_cnt;
    logic [7:0]        bad_cnt;
    logic              known;
    logic              want_resp;
    logic              take;
    resp_t             resp_d;

    // ==============================
    // Type decode and response build
    // ==============================
    always_comb begin
        known            = 1'b0;
        resp_d           = '0;
        resp_d.resp_type = msg.msg_type;
        case (msg.msg_type)
            `TYPE_NOP: known = 1'b1;
            `TYPE_LED_SET: known = 1'b1;
            `TYPE_ECHO: begin
                known          = 1'b1;
                resp_d.payload = msg.arg;
            end
            `TYPE_CMD6_STATUS: begin
                known          = 1'b1;
                resp_d.payload = {cmd6_status, drop_cnt, bad_cnt, 27'b0};
            end
            default: known = 1'b0;
        endcase
    end

    assign want_resp = msg_valid && known && msg.msg_type[`TYPE_RESP_BIT];
    assign take      = want_resp && (credit_cnt != '0);

    // ==============================
    // State and counters
    // ==============================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            led        <= 4'b0;
            credit_cnt <= CRED_W'(`RESP_DEPTH);
            drop_cnt   <= 8'b0;
            bad_cnt    <= 8'b0;
            resp_push  <= 1'b0;
        end else begin
            resp_push <= take;
            case ({take, resp_credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            if (msg_valid && msg.msg_type == `TYPE_LED_SET) begin
                led <= msg.arg[3:0];
            end
            // Response FIFO full, nothing goes out
            if (want_resp && !take) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
            if (msg_valid && !known) begin
                bad_cnt <= bad_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (take) begin
            resp <= resp_d;
        end
    end

endmodule

//--- msg_receiver.sv
`include "spi_ctrl_defines.svh"

module msg_receiver (
    input  logic               sd_datInWrite_clk,
    input  logic               sd_datInWrite_rst_,
    input  logic               data_in,
    output spi_ctrl_pkg::msg_t msg,
    output logic               msg_valid
);
    localparam int CNT_W = $clog2(`MSG_LEN);

    logic                busy;
    logic [CNT_W-1:0]    bit_cnt;
    logic [`MSG_LEN-1:0] shift_q;

    // Idle line is low, the first high bit is the start bit
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            busy      <= 1'b0;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (!busy) begin
                if (data_in) begin
                    busy    <= 1'b1;
                    bit_cnt <= CNT_W'(`MSG_LEN - 1);
                end
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == '0) begin
                    // Last bit taken this cycle
                    busy      <= 1'b0;
                    msg_valid <= 1'b1;
                end
            end
        end
    end

    // MSB first, so the type lands in the top byte
    always_ff @(posedge sd_datInWrite_clk) begin
        if (busy) begin
            shift_q <= {shift_q[`MSG_LEN-2:0], data_in};
        end
    end

    assign msg = shift_q;

endmodule

//--- credit_fifo.sv
`include "spi_ctrl_defines.svh"

module credit_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = `DATIN_DEPTH
) (
    input  logic     sd_datInWrite_clk,
    input  logic     sd_datInWrite_rst_,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     credit
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Writer is held off by credits, the full check is only a guard
    assign do_push   = push && (count != CNT_W'(DEPTH));
    assign do_pop    = pop && not_empty;
    assign not_empty = (count != '0);
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge sd_datInWrite_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            // One credit back per word taken out
            credit <= do_pop;
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- spi_ctrl_pkg.sv
`include "spi_ctrl_defines.svh"

package spi_ctrl_pkg;

    // ==============================
    // Serial control messages
    // ==============================

    // Type goes out first on the wire
    typedef struct packed {
        logic [`TYPE_LEN-1:0] msg_type;
        logic [`ARG_LEN-1:0]  arg;
    } msg_t;

    // Response echoes the type of its message
    typedef struct packed {
        logic [`TYPE_LEN-1:0] resp_type;
        logic [`ARG_LEN-1:0]  payload;
    } resp_t;

    // ==============================
    // SD data-in side
    // ==============================

    // One word of the 512-bit block
    typedef logic [15:0] datin_word_t;

    // CMD6 capture results, as reported in the status response
    typedef struct packed {
        logic [3:0] access_mode;
        logic       block_done;
        logic [7:0] block_count;
    } cmd6_status_t;

endpackage

//--- spi_ctrl_defines.svh
`ifndef SPI_CTRL_DEFINES_SVH
`define SPI_CTRL_DEFINES_SVH

// ==============================
// Serial message framing
// ==============================
`define MSG_LEN 64
`define TYPE_LEN 8
`define ARG_LEN 56
`define RESP_LEN 64

// FIFO depths, also the initial credit counts
`define DATIN_DEPTH 4
`define RESP_DEPTH 2

// CMD6 switch status block, 512 bits as 16-bit words
`define BLOCK_WORDS 32
`define ACCESS_WORD 8

// ==============================
// Message type codes
// ==============================
`define TYPE_NOP 8'h00
`define TYPE_LED_SET 8'h01
`define TYPE_ECHO 8'h80
`define TYPE_CMD6_STATUS 8'h81
`define TYPE_RESP_BIT 7

`endif
